// File: Makefile
# any variable below can be overridden, e.g. make sim LOG=run.log
VERILATOR ?= verilator
TOP       ?= pad_frame_tb
FILELIST  ?= pad_frame.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: pad_frame.f
rtl/pad_frame_pkg.sv
rtl/pad_frame_regs.sv
rtl/pingpong_frame_buf.sv
rtl/pad_col_emit.sv
rtl/pad_frame_top.sv
verif/pad_frame_tb.sv

// File: rtl/pad_col_emit.sv
// one frame in flight at a time; pad byte is latched at frame start and held to the last beat
module pad_col_emit (
  input  logic                             PEclk,
  input  logic                             rst_n,
  input  logic                             i_enable,
  input  logic [7:0]                       i_pad_val,
  input  logic                             i_frame_avail,
  input  logic                             i_rd_bank,
  input  logic [pad_frame_pkg::BANK_W-1:0] i_rd_col,
  input  logic                             i_col_ready,
  output pad_frame_pkg::rd_req_t           o_rd_req,
  output logic                             o_bank_release,
  output logic                             o_frame_done,
  output logic                             o_col_vld,
  output pad_frame_pkg::col_beat_t         o_col
);

  pad_frame_pkg::emit_state_e          state;
  pad_frame_pkg::col_beat_t            col_next;
  logic [pad_frame_pkg::COL_IDX_W-1:0] iss_cnt;    // next beat to fetch
  logic [pad_frame_pkg::COL_IDX_W-1:0] pend_beat;  // beat whose word is on i_rd_col
  logic                                pend_vld;
  logic [7:0]                          pad_q;
  logic                                bank_q;
  logic                                load;       // pending word moves to output
  logic                                issue;
  logic                                fire;       // last beat accepted

  assign load  = pend_vld & (~o_col_vld | i_col_ready);
  assign issue = (state == pad_frame_pkg::ST_EMIT) &&
                 (iss_cnt < pad_frame_pkg::OUT_BEATS) && (!pend_vld || load);
  assign fire  = o_col_vld & i_col_ready & o_col.last;

  assign o_bank_release = fire;
  assign o_frame_done   = fire;

  // hold the address of a stalled word so the buffer keeps returning it
  always_comb begin
    o_rd_req.bank = bank_q;
    o_rd_req.col  = issue ? iss_cnt - 1'b1 : pend_beat - 1'b1;
  end

  always_comb begin
    col_next.last = (pend_beat == pad_frame_pkg::OUT_BEATS - 1);
    col_next.data = {pad_frame_pkg::PAD_ROWS{pad_q}};  // border beats stay all pad
    if (pend_beat != 0 && !col_next.last) begin
      for (int r = 0; r < pad_frame_pkg::FRAME_ROWS; r++) begin
        col_next.data[pad_frame_pkg::COL_W-9-8*r -: 8] = i_rd_col[8*r +: 8];
      end
    end
  end

  always_ff @(posedge PEclk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= pad_frame_pkg::ST_IDLE;
      iss_cnt  <= '0;
      pend_vld <= 1'b0;
    end else begin
      case (state)
        pad_frame_pkg::ST_IDLE: if (i_enable && i_frame_avail) begin
          state   <= pad_frame_pkg::ST_EMIT;
          iss_cnt <= '0;
        end
        pad_frame_pkg::ST_EMIT: if (fire) begin
          state <= pad_frame_pkg::ST_IDLE;
        end
        default: state <= pad_frame_pkg::ST_IDLE;
      endcase
      if (issue) begin
        iss_cnt  <= iss_cnt + 1'b1;
        pend_vld <= 1'b1;
      end else if (load) begin
        pend_vld <= 1'b0;
      end
    end
  end

  always_ff @(posedge PEclk) begin
    if (state == pad_frame_pkg::ST_IDLE) begin
      pad_q  <= i_pad_val;  // frame-wide pad value
      bank_q <= i_rd_bank;
    end
    if (issue) begin
      pend_beat <= iss_cnt;
    end
  end

  always_ff @(posedge PEclk or negedge rst_n) begin
    if (!rst_n) begin
      o_col_vld <= 1'b0;
    end else if (load) begin
      o_col_vld <= 1'b1;
    end else if (i_col_ready) begin
      o_col_vld <= 1'b0;
    end
  end

  always_ff @(posedge PEclk) begin
    if (load) begin
      o_col <= col_next;
    end
  end

  a_col_stable : assert property (
    @(posedge PEclk) disable iff (!rst_n)
    (o_col_vld && !i_col_ready) |=> (o_col_vld && $stable(o_col))
  ) else $error("column changed while held");

endmodule

// File: rtl/pad_frame_pkg.sv
// fixed 24x32 frame with a one-byte pad ring; sizes here are not meant to be overridden
package pad_frame_pkg;

  localparam int FRAME_ROWS = 24;  // stored image rows
  localparam int FRAME_COLS = 32;  // stored image columns
  localparam int PAD_ROWS   = 26;  // bytes per padded column
  localparam int OUT_BEATS  = 34;  // padded columns per frame
  localparam int COL_W      = 208; // PAD_ROWS bytes
  localparam int BANK_W     = 192; // FRAME_ROWS bytes

  localparam int ROW_IDX_W  = 5;
  localparam int COL_IDX_W  = 6;   // also covers the 0..33 beat count
  localparam int APB_AW     = 4;

  // register map, byte offsets
  typedef enum logic [APB_AW-1:0] {
    ADDR_CTRL   = 4'd0,  // bit 0 enable
    ADDR_PAD    = 4'd4,  // bits 7:0 padding byte
    ADDR_STATUS = 4'd8   // read only
  } reg_addr_e;

  typedef enum logic {
    ST_IDLE,
    ST_EMIT
  } emit_state_e;

  // input stream payload
  typedef struct packed {
    logic [7:0] pix;
  } pix_beat_t;

  // output stream payload, row 0 sits just below the top pad byte
  typedef struct packed {
    logic [COL_W-1:0] data;
    logic             last;  // set on beat OUT_BEATS-1
  } col_beat_t;

  // emitter to buffer read request
  typedef struct packed {
    logic                 bank;
    logic [COL_IDX_W-1:0] col;
  } rd_req_t;

endpackage

// File: rtl/pad_frame_regs.sv
// APB slave, zero wait states; unmapped offsets flag pslverr, STATUS writes are dropped
module pad_frame_regs (
  input  logic                             PEclk,
  input  logic                             rst_n,
  input  logic                             i_psel,
  input  logic                             i_penable,
  input  logic                             i_pwrite,
  input  logic [pad_frame_pkg::APB_AW-1:0] i_paddr,
  input  logic [31:0]                      i_pwdata,
  input  logic                             i_frame_done,
  input  logic                             i_frame_avail,
  output logic [31:0]                      o_prdata,
  output logic                             o_pready,
  output logic                             o_pslverr,
  output logic                             o_enable,
  output logic [7:0]                       o_pad_val
);

  logic        access;      // access phase of a transfer
  logic        addr_hit;
  logic [15:0] frame_cnt;   // wraps at 64k

  assign access   = i_psel & i_penable;
  assign o_pready = 1'b1;   // never stretches the access phase

  always_comb begin
    case (i_paddr)
      pad_frame_pkg::ADDR_CTRL,
      pad_frame_pkg::ADDR_PAD,
      pad_frame_pkg::ADDR_STATUS: addr_hit = 1'b1;
      default:                    addr_hit = 1'b0;
    endcase
  end

  assign o_pslverr = access & ~addr_hit;

  always_ff @(posedge PEclk or negedge rst_n) begin
    if (!rst_n) begin
      o_enable  <= 1'b0;
      o_pad_val <= 8'h00;
    end else if (access && i_pwrite) begin
      case (i_paddr)
        pad_frame_pkg::ADDR_CTRL: o_enable  <= i_pwdata[0];
        pad_frame_pkg::ADDR_PAD:  o_pad_val <= i_pwdata[7:0];
        default: ;                // status and holes ignored
      endcase
    end
  end

  always_ff @(posedge PEclk or negedge rst_n) begin
    if (!rst_n) begin
      frame_cnt <= 16'd0;
    end else if (i_frame_done) begin
      frame_cnt <= frame_cnt + 16'd1;
    end
  end

  // read data is valid in the access cycle
  always_comb begin
    case (i_paddr)
      pad_frame_pkg::ADDR_CTRL:   o_prdata = {31'd0, o_enable};
      pad_frame_pkg::ADDR_PAD:    o_prdata = {24'd0, o_pad_val};
      pad_frame_pkg::ADDR_STATUS: o_prdata = {15'd0, i_frame_avail, frame_cnt};
      default:                    o_prdata = 32'd0;
    endcase
  end

  // bus master must open every transfer with a setup phase
  a_penable_needs_psel : assert property (
    @(posedge PEclk) disable iff (!rst_n)
    i_penable |-> i_psel
  ) else $error("penable high without psel");

endmodule

// File: rtl/pad_frame_top.sv
// single clock domain; pixels and columns use valid/ready, APB is configuration only
module pad_frame_top (
  input  logic                             PEclk,
  input  logic                             rst_n,
  input  logic                             i_psel,
  input  logic                             i_penable,
  input  logic                             i_pwrite,
  input  logic [pad_frame_pkg::APB_AW-1:0] i_paddr,
  input  logic [31:0]                      i_pwdata,
  output logic [31:0]                      o_prdata,
  output logic                             o_pready,
  output logic                             o_pslverr,
  input  logic                             i_pix_vld,
  input  pad_frame_pkg::pix_beat_t         i_pix,
  output logic                             o_pix_ready,
  output logic                             o_col_vld,
  output pad_frame_pkg::col_beat_t         o_col,
  input  logic                             i_col_ready
);

  logic                             enable;
  logic [7:0]                       pad_val;
  logic                             frame_done;
  logic                             frame_avail;
  logic                             rd_bank;
  logic [pad_frame_pkg::BANK_W-1:0] rd_col;
  logic                             bank_release;
  pad_frame_pkg::rd_req_t           rd_req;

  pad_frame_regs u_regs (
    .PEclk         (PEclk),
    .rst_n         (rst_n),
    .i_psel        (i_psel),
    .i_penable     (i_penable),
    .i_pwrite      (i_pwrite),
    .i_paddr       (i_paddr),
    .i_pwdata      (i_pwdata),
    .i_frame_done  (frame_done),
    .i_frame_avail (frame_avail),
    .o_prdata      (o_prdata),
    .o_pready      (o_pready),
    .o_pslverr     (o_pslverr),
    .o_enable      (enable),
    .o_pad_val     (pad_val)
  );

  pingpong_frame_buf u_buf (
    .PEclk          (PEclk),
    .rst_n          (rst_n),
    .i_enable       (enable),
    .i_pix_vld      (i_pix_vld),
    .i_pix          (i_pix),
    .i_rd_req       (rd_req),
    .i_bank_release (bank_release),
    .o_pix_ready    (o_pix_ready),
    .o_frame_avail  (frame_avail),
    .o_rd_bank      (rd_bank),
    .o_rd_col       (rd_col)
  );

  pad_col_emit u_emit (
    .PEclk          (PEclk),
    .rst_n          (rst_n),
    .i_enable       (enable),
    .i_pad_val      (pad_val),
    .i_frame_avail  (frame_avail),
    .i_rd_bank      (rd_bank),
    .i_rd_col       (rd_col),
    .i_col_ready    (i_col_ready),
    .o_rd_req       (rd_req),
    .o_bank_release (bank_release),
    .o_frame_done   (frame_done),
    .o_col_vld      (o_col_vld),
    .o_col          (o_col)
  );

endmodule

// File: rtl/pingpong_frame_buf.sv
// two banks of 32 column words; raster writes only, frames are read out oldest bank first
module pingpong_frame_buf (
  input  logic                             PEclk,
  input  logic                             rst_n,
  input  logic                             i_enable,
  input  logic                             i_pix_vld,
  input  pad_frame_pkg::pix_beat_t         i_pix,
  input  pad_frame_pkg::rd_req_t           i_rd_req,
  input  logic                             i_bank_release,
  output logic                             o_pix_ready,
  output logic                             o_frame_avail,
  output logic                             o_rd_bank,
  output logic [pad_frame_pkg::BANK_W-1:0] o_rd_col
);

  // column word holds one image column, byte lane = row
  logic [pad_frame_pkg::BANK_W-1:0] mem [2][pad_frame_pkg::FRAME_COLS];

  logic [pad_frame_pkg::ROW_IDX_W-1:0] wr_row;
  logic [pad_frame_pkg::COL_IDX_W-1:0] wr_col;
  logic                                wr_bank;   // bank being filled
  logic                                rd_ptr;    // oldest full bank
  logic [1:0]                          full;
  logic                                wr_fire;
  logic                                wr_last;   // last pixel of the frame
  logic [1:0]                          full_set;
  logic [1:0]                          full_clr;

  assign o_pix_ready = i_enable & ~full[wr_bank];
  assign wr_fire     = i_pix_vld & o_pix_ready;
  assign wr_last     = (wr_row == pad_frame_pkg::FRAME_ROWS - 1) &&
                       (wr_col == pad_frame_pkg::FRAME_COLS - 1);

  assign full_set = (wr_fire && wr_last) ? (2'b01 << wr_bank) : 2'b00;
  assign full_clr = i_bank_release ? (2'b01 << rd_ptr) : 2'b00;

  assign o_frame_avail = full[rd_ptr];
  assign o_rd_bank     = rd_ptr;

  // raster counters, column runs fastest
  always_ff @(posedge PEclk or negedge rst_n) begin
    if (!rst_n) begin
      wr_row  <= '0;
      wr_col  <= '0;
      wr_bank <= 1'b0;
    end else if (wr_fire) begin
      if (wr_col == pad_frame_pkg::FRAME_COLS - 1) begin
        wr_col <= '0;
        if (wr_last) begin
          wr_row  <= '0;
          wr_bank <= ~wr_bank;  // next frame goes to the other bank
        end else begin
          wr_row <= wr_row + 1'b1;
        end
      end else begin
        wr_col <= wr_col + 1'b1;
      end
    end
  end

  // set and clear never hit the same bank
  always_ff @(posedge PEclk or negedge rst_n) begin
    if (!rst_n) begin
      full   <= 2'b00;
      rd_ptr <= 1'b0;
    end else begin
      full <= (full & ~full_clr) | full_set;
      if (i_bank_release) begin
        rd_ptr <= ~rd_ptr;
      end
    end
  end

  always_ff @(posedge PEclk) begin
    if (wr_fire) begin
      mem[wr_bank][wr_col[pad_frame_pkg::COL_IDX_W-2:0]][wr_row*8 +: 8] <= i_pix.pix;
    end
  end

  // one cycle read latency, upper col bit is always 0 for stored columns
  always_ff @(posedge PEclk) begin
    o_rd_col <= mem[i_rd_req.bank][i_rd_req.col[pad_frame_pkg::COL_IDX_W-2:0]];
  end

  // a lone full bank is the oldest one and the writer sits on the other
  a_no_write_into_read_bank : assert property (
    @(posedge PEclk) disable iff (!rst_n)
    (full == 2'b01 || full == 2'b10) |-> (full[rd_ptr] && wr_bank != rd_ptr)
  ) else $error("lone full bank is not the oldest or is still being written");

  a_release_full_bank : assert property (
    @(posedge PEclk) disable iff (!rst_n)
    i_bank_release |-> full[rd_ptr]
  ) else $error("bank release without a full bank");

endmodule

// File: verif/pad_frame_stimulus.txt
# cmd  args in hex: W addr data err | R addr expected err | F seed pad
# B on (output back-pressure) | Z cycles (pixels offered while disabled) | D (drain) | T name
T reset_values
R 0 00000000 0
R 4 00000000 0
R 8 00000000 0
Z 14
T single_frame
W 4 000000a5 0
W 0 00000001 0
F 10 a5
D
R 8 00000001 0
T two_frames
F 37 a5
W 4 0000005c 0
F c8 5c
D
R 8 00000003 0
T back_pressure
B 1
F 5e 5c
F e1 5c
D
B 0
R 8 00000005 0
T bad_address
R c 00000000 1
W c 000000ff 1
R 2 00000000 1
W 8 0000ffff 0
R 8 00000005 0
R 0 00000001 0
R 4 0000005c 0

// File: verif/pad_frame_tb.sv
// commands and expected values come from verif/pad_frame_stimulus.txt, run from the project root
module pad_frame_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam string STIM_FILE     = "verif/pad_frame_stimulus.txt";
  localparam int    SAMPLE_DLY    = 2;      // mid low phase
  localparam int    APB_TIMEOUT   = 16;
  localparam int    PIX_TIMEOUT   = 4000;   // cycles per pixel
  localparam int    DRAIN_TIMEOUT = 20000;

  typedef struct packed {
    logic [7:0] fseed;
    logic [7:0] pad;
  } frame_exp_t;

  logic                             PEclk = 1'b0;
  logic                             rst_n;
  logic                             i_psel;
  logic                             i_penable;
  logic                             i_pwrite;
  logic [pad_frame_pkg::APB_AW-1:0] i_paddr;
  logic [31:0]                      i_pwdata;
  logic [31:0]                      o_prdata;
  logic                             o_pready;
  logic                             o_pslverr;
  logic                             i_pix_vld;
  pad_frame_pkg::pix_beat_t         i_pix;
  logic                             o_pix_ready;
  logic                             o_col_vld;
  pad_frame_pkg::col_beat_t         o_col;
  logic                             i_col_ready = 1'b1;

  frame_exp_t exp_frames[$];  // every frame sent, in order
  int         frames_out;     // frames fully seen at the output
  int         beat_idx;
  int         err_cnt;
  int         col_err_cnt;
  int         err_mark;
  int         pass_tests;
  int         fail_tests;
  bit         test_open;
  bit         hung;
  bit         bp_on = 1'b0;
  integer     seed;
  string      test_name;

  pad_frame_top u_dut (
    .PEclk       (PEclk),
    .rst_n       (rst_n),
    .i_psel      (i_psel),
    .i_penable   (i_penable),
    .i_pwrite    (i_pwrite),
    .i_paddr     (i_paddr),
    .i_pwdata    (i_pwdata),
    .o_prdata    (o_prdata),
    .o_pready    (o_pready),
    .o_pslverr   (o_pslverr),
    .i_pix_vld   (i_pix_vld),
    .i_pix       (i_pix),
    .o_pix_ready (o_pix_ready),
    .o_col_vld   (o_col_vld),
    .o_col       (o_col),
    .i_col_ready (i_col_ready)
  );

  always #4 PEclk = ~PEclk;

  // beat k of a frame, row 0 just below the top pad byte
  function automatic pad_frame_pkg::col_beat_t expected_col(input logic [7:0] fseed,
                                                            input logic [7:0] pad,
                                                            input int beat);
    pad_frame_pkg::col_beat_t col;
    logic [7:0]               b;
    col.last = (beat == pad_frame_pkg::OUT_BEATS - 1);
    for (int r = 0; r < pad_frame_pkg::PAD_ROWS; r++) begin
      b = pad;
      if (beat >= 1 && beat <= pad_frame_pkg::FRAME_COLS &&
          r >= 1 && r <= pad_frame_pkg::FRAME_ROWS) begin
        b = fseed + 8'(pad_frame_pkg::FRAME_COLS * (r - 1) + beat - 1);
      end
      col.data[pad_frame_pkg::COL_W - 1 - 8*r -: 8] = b;
    end
    return col;
  endfunction

  task automatic check_col(input string name, input pad_frame_pkg::col_beat_t exp_v,
                           input pad_frame_pkg::col_beat_t act_v);
    if (act_v !== exp_v) begin
      $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp_v, act_v);
      col_err_cnt++;
    end
  endtask

  task automatic check_reg(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    if (act_v !== exp_v) begin
      $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp_v, act_v);
      err_cnt++;
    end
  endtask

  task automatic take_beat(input pad_frame_pkg::col_beat_t col);
    frame_exp_t fe;
    if (frames_out >= exp_frames.size()) begin
      $display("%0t ns: a column came out while no frame was expected", $time);
      col_err_cnt++;
    end else begin
      fe = exp_frames[frames_out];
      check_col($sformatf("o_col beat %0d", beat_idx), expected_col(fe.fseed, fe.pad, beat_idx),
                col);
      if (beat_idx == pad_frame_pkg::OUT_BEATS - 1) begin
        beat_idx = 0;
        frames_out++;
      end else begin
        beat_idx++;
      end
    end
  endtask

  // ready set here holds through the next rising edge, so vld and ready now mean a transfer
  always @(negedge PEclk) begin
    logic ready_now;
    ready_now = bp_on ? 1'($random(seed)) : 1'b1;
    i_col_ready = ready_now;
    if (rst_n && o_col_vld && ready_now) begin
      take_beat(o_col);
    end
  end

  task automatic apb_access(input logic write, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr);
    int cyc;
    i_psel    = 1'b1;
    i_penable = 1'b0;
    i_pwrite  = write;
    i_paddr   = addr[pad_frame_pkg::APB_AW-1:0];
    i_pwdata  = wdata;
    @(negedge PEclk);
    i_penable = 1'b1;
    cyc = 0;
    while (!hung) begin
      #SAMPLE_DLY;
      if (o_pready) break;
      cyc++;
      if (cyc > APB_TIMEOUT) begin
        $display("timeout: pready never rose on an APB access");
        err_cnt++;
        hung = 1'b1;
      end
      @(negedge PEclk);
    end
    rdata  = o_prdata;
    slverr = o_pslverr;
    @(negedge PEclk);
    i_psel    = 1'b0;
    i_penable = 1'b0;
    i_pwrite  = 1'b0;
  endtask

  // raster order, column fastest
  task automatic send_frame(input logic [7:0] fseed);
    int cyc;
    for (int r = 0; r < pad_frame_pkg::FRAME_ROWS && !hung; r++) begin
      for (int c = 0; c < pad_frame_pkg::FRAME_COLS && !hung; c++) begin
        i_pix_vld = 1'b1;
        i_pix.pix = fseed + 8'(32 * r + c);
        cyc = 0;
        while (!o_pix_ready && !hung) begin
          @(negedge PEclk);
          cyc++;
          if (cyc > PIX_TIMEOUT) begin
            $display("timeout: pixel (%0d,%0d) was never accepted", r, c);
            err_cnt++;
            hung = 1'b1;
          end
        end
        @(negedge PEclk);
      end
    end
    i_pix_vld = 1'b0;
  endtask

  task automatic check_idle(input int cycles);
    i_pix_vld = 1'b1;
    i_pix.pix = 8'h5a;
    for (int i = 0; i < cycles; i++) begin
      check_reg("o_pix_ready", 32'd0, {31'd0, o_pix_ready});
      @(negedge PEclk);
    end
    i_pix_vld = 1'b0;
  endtask

  task automatic drain_frames();
    int cyc;
    cyc = 0;
    while (exp_frames.size() > frames_out && !hung) begin
      @(posedge PEclk);
      cyc++;
      if (cyc > DRAIN_TIMEOUT) begin
        $display("timeout: %0d frames never came out", exp_frames.size() - frames_out);
        err_cnt++;
        hung = 1'b1;
      end
    end
    @(negedge PEclk);
  endtask

  task automatic close_test();
    int errs;
    errs = err_cnt + col_err_cnt - err_mark;
    if (test_open) begin
      if (errs == 0) begin
        $display("test %s: pass", test_name);
        pass_tests++;
      end else begin
        $display("test %s: fail, %0d errors", test_name, errs);
        fail_tests++;
      end
    end
    test_open = 1'b0;
  endtask

  task automatic run_command(input string line, input string cmd);
    string       tag;
    int          n;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    logic [31:0] rdata;
    logic        slverr;
    frame_exp_t  fe;
    n = $sscanf(line, "%s %h %h %h", tag, a, d, e);
    if (cmd == "T") begin
      close_test();
      n = $sscanf(line, "%s %s", tag, test_name);
      err_mark  = err_cnt + col_err_cnt;
      test_open = 1'b1;
    end else if (cmd == "W" || cmd == "R") begin
      apb_access(cmd == "W", a, cmd == "W" ? d : 32'd0, rdata, slverr);
      if (cmd == "R") begin
        check_reg("o_prdata", d, rdata);
      end
      check_reg("o_pslverr", {31'd0, e[0]}, {31'd0, slverr});
    end else if (cmd == "F") begin
      fe.fseed = a[7:0];
      fe.pad   = d[7:0];
      exp_frames.push_back(fe);
      send_frame(a[7:0]);
    end else if (cmd == "B") begin
      @(posedge PEclk);
      bp_on = a[0];  // changed away from the falling edge
      @(negedge PEclk);
    end else if (cmd == "Z") begin
      check_idle(a);
    end else if (cmd == "D") begin
      drain_frames();
    end else begin
      $display("unknown command %s in the stimulus file", cmd);
      err_cnt++;
    end
  endtask

  initial begin
    int    fd;
    string line;
    string cmd;
    seed      = 83;
    rst_n     = 1'b0;
    i_psel    = 1'b0;
    i_penable = 1'b0;
    i_pwrite  = 1'b0;
    i_paddr   = '0;
    i_pwdata  = '0;
    i_pix_vld = 1'b0;
    i_pix     = '0;
    repeat (3) @(negedge PEclk);
    rst_n = 1'b1;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file %s", STIM_FILE);
      err_cnt++;
    end else begin
      while (!hung && $fgets(line, fd) != 0) begin
        if ($sscanf(line, "%s", cmd) == 1 && cmd.getc(0) != "#") begin
          run_command(line, cmd);
        end
      end
      $fclose(fd);
    end
    if (!hung && exp_frames.size() != frames_out) begin
      $display("%0d frames still expected at the end of the run", exp_frames.size() - frames_out);
      err_cnt++;
    end
    close_test();
    $display("tests passed %0d, tests failed %0d", pass_tests, fail_tests);
    if (err_cnt + col_err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
